// ==== Bender.yml ====
package:
  name: usrp_rx

sources:
  - include_dirs:
      - .
    files:
      - usrp_rx_pkg.sv
      - rx_chan_if.sv
      - setting_reg.sv
      - rx_strobe_gen.sv
      - rx_source_select.sv
      - rx_sample_fifo.sv
      - usrp_rx_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_usrp_rx_top.sv

// ==== filelist.f ====
+incdir+.
usrp_rx_pkg.sv
rx_chan_if.sv
setting_reg.sv
rx_strobe_gen.sv
rx_source_select.sv
rx_sample_fifo.sv
usrp_rx_top.sv
tb_usrp_rx_top.sv

// ==== rx_chan_if.sv ====
/*
 * Channel frame link from source selector to sample FIFO
 *   - one-cycle frame strobe
 *   - four-channel frame and its channel count
 */

`default_nettype none

interface rx_chan_if;

   // Frame and four_chan are valid while frame_strobe is high
   logic                      frame_strobe;
   usrp_rx_pkg::chan_frame_t  frame;
   logic                      four_chan;

   modport source
   (
      output frame_strobe,
      output frame,
      output four_chan
   );

   modport sink
   (
      input frame_strobe,
      input frame,
      input four_chan
   );

endinterface

`default_nettype wire

// ==== rx_sample_fifo.sv ====
/*
 * Receive sample FIFO
 *   - accepts or drops a whole frame at frame strobe time
 *   - word sequencer writes ch0..ch3 on consecutive cycles
 *   - first-word-fall-through read port
 *   - sticky overrun flag cleared by clear_status
 */

`default_nettype none

`include "usrp_rx_config.svh"

module rx_sample_fifo
(
   input  wire logic             clk64,
   input  wire logic             i_rx_dsp_reset,
   rx_chan_if.sink               chan,
   input  wire logic             i_rd,
   input  wire logic             i_clear_status,
   output usrp_rx_pkg::sample_t  o_rd_data,
   output logic                  o_empty,
   output logic                  o_rx_overrun
);

   localparam int unsigned DEPTH = `RX_FIFO_DEPTH;
   localparam int unsigned AW    = $clog2(DEPTH);

   usrp_rx_pkg::sample_t      mem [DEPTH];
   logic [AW-1:0]             wr_ptr;
   logic [AW-1:0]             rd_ptr;
   logic [AW:0]               count;
   logic [AW:0]               free_words;
   usrp_rx_pkg::chan_count_t  frame_len;
   usrp_rx_pkg::chan_count_t  seq_left;
   logic [1:0]                seq_idx;
   usrp_rx_pkg::chan_frame_t  frame_hold;
   usrp_rx_pkg::sample_t      wr_data;
   logic                      accept;
   logic                      wr_en;
   logic                      rd_en;

   assign frame_len  = chan.four_chan ? 3'd4 : 3'd2;
   assign free_words = (AW+1)'(DEPTH) - count;
   assign accept     = chan.frame_strobe && (free_words >= (AW+1)'(frame_len));

   // First word goes straight from the link, the rest from the hold register
   assign wr_en   = accept || (seq_left != 3'd0);
   assign wr_data = accept ? chan.frame[0] : frame_hold[seq_idx];
   assign rd_en   = i_rd && !o_empty;

   assign o_empty   = (count == '0);
   assign o_rd_data = mem[rd_ptr];

   // Word sequencer
   always_ff @(posedge clk64)
   begin
      if (i_rx_dsp_reset)
      begin
         seq_left <= 3'd0;
         seq_idx  <= 2'd0;
      end
      else if (accept)
      begin
         seq_left <= frame_len - 3'd1;
         seq_idx  <= 2'd1;
      end
      else if (seq_left != 3'd0)
      begin
         seq_left <= seq_left - 3'd1;
         seq_idx  <= seq_idx + 2'd1;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (accept)
      begin
         frame_hold <= chan.frame;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (wr_en)
      begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk64)
   begin
      if (i_rx_dsp_reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + (AW+1)'(wr_en) - (AW+1)'(rd_en);
      end
   end

   // A drop in the same cycle as a clear keeps the flag set
   always_ff @(posedge clk64)
   begin
      if (i_rx_dsp_reset)
      begin
         o_rx_overrun <= 1'b0;
      end
      else if (chan.frame_strobe && !accept)
      begin
         o_rx_overrun <= 1'b1;
      end
      else if (i_clear_status)
      begin
         o_rx_overrun <= 1'b0;
      end
   end

   a_no_write_full: assert property (@(posedge clk64) disable iff (i_rx_dsp_reset)
      wr_en |-> (count < (AW+1)'(DEPTH)))
      else $error("sample FIFO written while full");

   a_no_read_empty: assert property (@(posedge clk64) disable iff (i_rx_dsp_reset)
      i_rd |-> !o_empty)
      else $error("sample FIFO read while empty");

endmodule

`default_nettype wire

// ==== rx_source_select.sv ====
/*
 * Receive source selector
 *   - debug counter stepping by two per sample strobe
 *   - transmit loopback latch
 *   - channel 0/1 source mux, counter over loopback over ADC
 *   - registers the frame and its strobe one cycle after the sample strobe
 */

`default_nettype none

module rx_source_select
(
   input  wire logic                   clk64,
   input  wire logic                   i_rx_dsp_reset,
   input  wire logic                   i_enable_rx,
   input  wire logic                   i_sample_strobe,
   input  wire usrp_rx_pkg::rx_mode_t  i_mode,
   input  wire usrp_rx_pkg::sample_t   i_adc_i0,
   input  wire usrp_rx_pkg::sample_t   i_adc_q0,
   input  wire usrp_rx_pkg::sample_t   i_adc_i1,
   input  wire usrp_rx_pkg::sample_t   i_adc_q1,
   input  wire usrp_rx_pkg::sample_t   i_tx_i0,
   input  wire usrp_rx_pkg::sample_t   i_tx_q0,
   input  wire logic                   i_tx_strobe,
   rx_chan_if.source                   chan
);

   logic [15:0]           debug_counter;
   usrp_rx_pkg::sample_t  loopback_i0;
   usrp_rx_pkg::sample_t  loopback_q0;
   usrp_rx_pkg::sample_t  ch0;
   usrp_rx_pkg::sample_t  ch1;

   // Restarts from zero whenever receive is disabled
   always_ff @(posedge clk64)
   begin
      if (i_rx_dsp_reset || !i_enable_rx)
      begin
         debug_counter <= 16'd0;
      end
      else if (i_sample_strobe)
      begin
         debug_counter <= debug_counter + 16'd2;
      end
   end

   // Last transmit pair seen on the transmit strobe
   always_ff @(posedge clk64)
   begin
      if (i_tx_strobe)
      begin
         loopback_i0 <= i_tx_i0;
         loopback_q0 <= i_tx_q0;
      end
   end

   always_comb
   begin
      if (i_mode.counter)
      begin
         ch0 = usrp_rx_pkg::sample_t'(debug_counter);
         ch1 = usrp_rx_pkg::sample_t'(debug_counter + 16'd1);
      end
      else if (i_mode.loopback)
      begin
         ch0 = loopback_i0;
         ch1 = loopback_q0;
      end
      else
      begin
         ch0 = i_adc_i0;
         ch1 = i_adc_q0;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (i_rx_dsp_reset)
      begin
         chan.frame_strobe <= 1'b0;
      end
      else
      begin
         chan.frame_strobe <= i_sample_strobe;
      end
   end

   // Frame holds until the next strobe
   always_ff @(posedge clk64)
   begin
      if (i_sample_strobe)
      begin
         chan.frame     <= {i_adc_q1, i_adc_i1, ch1, ch0};
         chan.four_chan <= i_mode.four_chan;
      end
   end

   a_frame_follows_strobe: assert property (@(posedge clk64) disable iff (i_rx_dsp_reset)
      chan.frame_strobe |-> $past(i_sample_strobe))
      else $error("frame strobe without a preceding sample strobe");

endmodule

`default_nettype wire

// ==== rx_strobe_gen.sv ====
/*
 * Receive sample strobe generator
 *   - down-counter reloaded with max(decim+1, minimum period)
 *   - one-cycle strobe each time the counter reaches zero
 */

`default_nettype none

`include "usrp_rx_config.svh"

module rx_strobe_gen
(
   input  wire logic               clk64,
   input  wire logic               i_rx_dsp_reset,
   input  wire logic               i_enable_rx,
   input  wire usrp_rx_pkg::rate_t i_decim_rate,
   output logic                    o_sample_strobe
);

   logic [8:0] period_raw;
   logic [8:0] period;
   logic [8:0] count;

   // Clamp short periods so a full frame drains between strobes
   assign period_raw = {1'b0, i_decim_rate} + 9'd1;
   assign period     = (period_raw < 9'(`RX_MIN_PERIOD)) ? 9'(`RX_MIN_PERIOD) : period_raw;

   always_ff @(posedge clk64)
   begin
      if (i_rx_dsp_reset || !i_enable_rx)
      begin
         count           <= '0;
         o_sample_strobe <= 1'b0;
      end
      else if (count == 9'd0)
      begin
         count           <= period - 9'd1;
         o_sample_strobe <= 1'b1;
      end
      else
      begin
         count           <= count - 9'd1;
         o_sample_strobe <= 1'b0;
      end
   end

   // Strobes stay at least the minimum period apart
   a_strobe_spacing: assert property (@(posedge clk64) disable iff (i_rx_dsp_reset)
      o_sample_strobe |=> !o_sample_strobe [*(`RX_MIN_PERIOD - 1)])
      else $error("sample strobes closer than the minimum period");

endmodule

`default_nettype wire

// ==== setting_reg.sv ====
/*
 * Settings-bus register
 *   - matches its own address on each serial strobe
 *   - loads the low bits of the data word as one payload type
 */

`default_nettype none

module setting_reg
#(
   parameter logic [6:0] ADDR = 7'd0,
   parameter type payload_t = logic [31:0]
)
(
   input  wire logic        clk64,
   input  wire logic        i_rx_dsp_reset,
   input  wire logic        i_serial_strobe,
   input  wire logic [6:0]  i_serial_addr,
   input  wire logic [31:0] i_serial_data,
   output payload_t         o_value
);

   localparam int unsigned PW = $bits(payload_t);

   always_ff @(posedge clk64)
   begin
      if (i_rx_dsp_reset)
      begin
         o_value <= payload_t'(0);
      end
      else if (i_serial_strobe && (i_serial_addr == ADDR))
      begin
         o_value <= payload_t'(i_serial_data[PW-1:0]);
      end
   end

   // Payload must come from the 32-bit data word
   a_payload_fits: assert property (@(posedge clk64) PW <= 32)
      else $error("setting_reg payload wider than the data word");

endmodule

`default_nettype wire

// ==== tb_usrp_rx_top.sv ====
/*
 * Testbench for the receive top level
 *   - 32-bit Fibonacci LFSR for all random stimulus
 *   - reference model with an expected-word queue and free-space rule
 *   - compare tasks for samples, flags and cycle counts
 *   - ADC, four-channel, counter, loopback, overrun and strobe spacing tests
 */

`default_nettype none

`include "usrp_rx_config.svh"

module tb_usrp_rx_top;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int DEPTH      = `RX_FIFO_DEPTH;
   localparam int WAIT_LIMIT = 4000;

   logic                  clk64           = 1'b0;
   logic                  i_rx_dsp_reset  = 1'b1;
   logic                  i_enable_rx     = 1'b0;
   logic                  i_serial_strobe = 1'b0;
   logic [6:0]            i_serial_addr   = 7'd0;
   logic [31:0]           i_serial_data   = 32'd0;
   usrp_rx_pkg::sample_t  i_adc_i0        = '0;
   usrp_rx_pkg::sample_t  i_adc_q0        = '0;
   usrp_rx_pkg::sample_t  i_adc_i1        = '0;
   usrp_rx_pkg::sample_t  i_adc_q1        = '0;
   usrp_rx_pkg::sample_t  i_tx_i0         = '0;
   usrp_rx_pkg::sample_t  i_tx_q0         = '0;
   logic                  i_tx_strobe     = 1'b0;
   logic                  i_rd            = 1'b0;
   logic                  i_clear_status  = 1'b0;
   logic                  o_sample_strobe;
   usrp_rx_pkg::sample_t  o_rd_data;
   logic                  o_empty;
   logic                  o_rx_overrun;

   // Reference model state
   logic [31:0]            lfsr_state = 32'h83e6;
   usrp_rx_pkg::sample_t   exp_q[$];
   usrp_rx_pkg::rx_mode_t  model_mode = '0;
   logic [15:0]            model_counter = 16'd0;
   usrp_rx_pkg::sample_t   model_lb_i = '0;
   usrp_rx_pkg::sample_t   model_lb_q = '0;
   bit                     exp_overrun = 1'b0;
   bit                     read_on = 1'b0;
   int                     frames_seen = 0;
   int                     words_popped = 0;

   always #2 clk64 = ~clk64;

   usrp_rx_top usrp_rx_top_inst
   (
      .clk64           (clk64),
      .i_rx_dsp_reset  (i_rx_dsp_reset),
      .i_enable_rx     (i_enable_rx),
      .i_serial_strobe (i_serial_strobe),
      .i_serial_addr   (i_serial_addr),
      .i_serial_data   (i_serial_data),
      .i_adc_i0        (i_adc_i0),
      .i_adc_q0        (i_adc_q0),
      .i_adc_i1        (i_adc_i1),
      .i_adc_q1        (i_adc_q1),
      .i_tx_i0         (i_tx_i0),
      .i_tx_q0         (i_tx_q0),
      .i_tx_strobe     (i_tx_strobe),
      .i_rd            (i_rd),
      .i_clear_status  (i_clear_status),
      .o_sample_strobe (o_sample_strobe),
      .o_rd_data       (o_rd_data),
      .o_empty         (o_empty),
      .o_rx_overrun    (o_rx_overrun)
   );

   // Taps 32, 22, 2, 1; one step per output bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic        fb;
      int          k;
      v = '0;
      for (k = 0; k < n; k++)
      begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v          = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_sample(input string sig, input usrp_rx_pkg::sample_t got,
                               input usrp_rx_pkg::sample_t exp);
      if (got !== exp)
         abort_run($sformatf("MISMATCH time=%0t %s got=%0d expected=%0d",
                             $time, sig, got, exp));
   endtask

   task automatic check_flag(input string sig, input bit got, input bit exp);
      if (got !== exp)
         abort_run($sformatf("MISMATCH time=%0t %s got=%0b expected=%0b",
                             $time, sig, got, exp));
   endtask

   task automatic check_count(input string sig, input int got, input int exp);
      if (got != exp)
         abort_run($sformatf("MISMATCH time=%0t %s got=%0d expected=%0d",
                             $time, sig, got, exp));
   endtask

   // Model, reader and per-cycle stimulus, all on the rising edge
   always @(posedge clk64)
   begin
      usrp_rx_pkg::sample_t w0;
      usrp_rx_pkg::sample_t w1;
      int                   flen;
      if (i_rx_dsp_reset)
      begin
         exp_q.delete();
         i_rd <= 1'b0;
      end
      else
      begin
         if (i_rd && !o_empty)
         begin
            if (exp_q.size() == 0)
               abort_run("DUT delivered a word that the model did not expect");
            else
               check_sample("o_rd_data", o_rd_data, exp_q.pop_front());
            words_popped <= words_popped + 1;
         end
         if (o_sample_strobe)
         begin
            if (model_mode.counter)
            begin
               w0 = usrp_rx_pkg::sample_t'(model_counter);
               w1 = usrp_rx_pkg::sample_t'(model_counter + 16'd1);
            end
            else if (model_mode.loopback)
            begin
               w0 = model_lb_i;
               w1 = model_lb_q;
            end
            else
            begin
               w0 = i_adc_i0;
               w1 = i_adc_q0;
            end
            flen = model_mode.four_chan ? 4 : 2;
            // Whole frame is kept only if it fits
            if (DEPTH - exp_q.size() >= flen)
            begin
               exp_q.push_back(w0);
               exp_q.push_back(w1);
               if (model_mode.four_chan)
               begin
                  exp_q.push_back(i_adc_i1);
                  exp_q.push_back(i_adc_q1);
               end
            end
            else
            begin
               exp_overrun = 1'b1;
            end
            frames_seen <= frames_seen + 1;
         end
         // Only read when no pop is under way, so the FIFO cannot empty under i_rd
         i_rd <= read_on && !i_rd && !o_empty && (take_bits(2) != 2'd0);
      end
      if (i_rx_dsp_reset || !i_enable_rx)
         model_counter = 16'd0;
      else if (o_sample_strobe)
         model_counter = model_counter + 16'd2;
      if (i_tx_strobe)
      begin
         model_lb_i = i_tx_i0;
         model_lb_q = i_tx_q0;
      end
      i_adc_i0    <= usrp_rx_pkg::sample_t'(take_bits(16));
      i_adc_q0    <= usrp_rx_pkg::sample_t'(take_bits(16));
      i_adc_i1    <= usrp_rx_pkg::sample_t'(take_bits(16));
      i_adc_q1    <= usrp_rx_pkg::sample_t'(take_bits(16));
      i_tx_i0     <= usrp_rx_pkg::sample_t'(take_bits(16));
      i_tx_q0     <= usrp_rx_pkg::sample_t'(take_bits(16));
      i_tx_strobe <= (take_bits(2) == 2'd0);
   end

   // Draws away from the rising edge keep the LFSR order fixed
   task automatic draw_bits(input int n, output logic [31:0] v);
      @(negedge clk64);
      v = take_bits(n);
   endtask

   task automatic write_setting(input logic [6:0] addr, input logic [31:0] data);
      @(posedge clk64);
      i_serial_strobe <= 1'b1;
      i_serial_addr   <= addr;
      i_serial_data   <= data;
      @(posedge clk64);
      i_serial_strobe <= 1'b0;
   endtask

   task automatic set_mode(input bit counter, input bit loopback, input bit four_chan);
      model_mode.counter   = counter;
      model_mode.loopback  = loopback;
      model_mode.four_chan = four_chan;
      write_setting(`RX_ADDR_MODE, 32'(model_mode));
   endtask

   task automatic set_rate(input int base, input int rand_width);
      logic [31:0] v;
      draw_bits(rand_width, v);
      write_setting(`RX_ADDR_DECIM, 32'(base) + v);
   endtask

   task automatic start_rx(input bit reader);
      @(posedge clk64);
      i_enable_rx <= 1'b1;
      read_on     <= reader;
   endtask

   task automatic run_frames(input int n);
      int target;
      int t;
      target = frames_seen + n;
      t      = 0;
      while (frames_seen < target)
      begin
         if (t == n * 400)
            abort_run("timeout waiting for sample frames");
         t++;
         @(posedge clk64);
      end
   endtask

   // Head word after enable must be the counter start value
   task automatic check_first_word_zero();
      int t;
      t = 0;
      @(posedge clk64);
      while (o_empty)
      begin
         if (t == WAIT_LIMIT)
            abort_run("timeout waiting for the first FIFO word");
         t++;
         @(posedge clk64);
      end
      check_sample("o_rd_data", o_rd_data, 16'sd0);
      read_on <= 1'b1;
   endtask

   task automatic clear_status();
      @(posedge clk64);
      i_clear_status <= 1'b1;
      @(posedge clk64);
      i_clear_status <= 1'b0;
      exp_overrun = 1'b0;
      @(posedge clk64);
      check_flag("o_rx_overrun", o_rx_overrun, 1'b0);
   endtask

   task automatic stop_and_drain();
      int t;
      @(posedge clk64);
      i_enable_rx <= 1'b0;
      // Last strobe, frame register and four writes settle within this window
      repeat (8) @(posedge clk64);
      read_on <= 1'b1;
      t = 0;
      @(posedge clk64);
      while (!o_empty || i_rd)
      begin
         if (t == WAIT_LIMIT)
            abort_run("timeout waiting for the FIFO to drain");
         t++;
         @(posedge clk64);
      end
      read_on <= 1'b0;
      if (exp_q.size() != 0)
         abort_run($sformatf("FIFO is empty but %0d expected words are missing",
                             exp_q.size()));
      check_flag("o_rx_overrun", o_rx_overrun, exp_overrun);
      clear_status();
   endtask

   task automatic measure_gaps(input int rate);
      int t;
      int gap;
      int k;
      int exp_gap;
      exp_gap = (rate + 1 < `RX_MIN_PERIOD) ? `RX_MIN_PERIOD : rate + 1;
      t = 0;
      @(posedge clk64);
      while (!o_sample_strobe)
      begin
         if (t == WAIT_LIMIT)
            abort_run("timeout waiting for a sample strobe");
         t++;
         @(posedge clk64);
      end
      for (k = 0; k < 3; k++)
      begin
         gap = 0;
         do
         begin
            if (gap == WAIT_LIMIT)
               abort_run("timeout waiting for the next sample strobe");
            gap++;
            @(posedge clk64);
         end
         while (!o_sample_strobe);
         check_count("o_sample_strobe gap", gap, exp_gap);
      end
   endtask

   initial
   begin
      logic [31:0] v;
      int          k;
      int          popped_before;
      repeat (5) @(posedge clk64);
      i_rx_dsp_reset <= 1'b0;
      @(posedge clk64);

      // FIFO leaves reset empty and without overrun
      check_flag("o_empty", o_empty, 1'b1);
      check_flag("o_rx_overrun", o_rx_overrun, 1'b0);

      // ADC pair 0, two channels
      set_mode(1'b0, 1'b0, 1'b0);
      set_rate(4, 4);
      start_rx(1'b1);
      run_frames(20);
      stop_and_drain();

      // Four channels
      set_mode(1'b0, 1'b0, 1'b1);
      set_rate(12, 4);
      start_rx(1'b1);
      run_frames(16);
      stop_and_drain();

      // Counter mode, then a restart after enable drops
      set_mode(1'b1, 1'b0, 1'b0);
      set_rate(6, 3);
      start_rx(1'b0);
      check_first_word_zero();
      run_frames(10);
      stop_and_drain();
      start_rx(1'b0);
      check_first_word_zero();
      run_frames(6);
      stop_and_drain();

      // Loopback, then counter over loopback
      set_mode(1'b0, 1'b1, 1'b0);
      set_rate(5, 4);
      start_rx(1'b1);
      run_frames(16);
      stop_and_drain();
      set_mode(1'b1, 1'b1, 1'b1);
      set_rate(12, 3);
      start_rx(1'b0);
      check_first_word_zero();
      run_frames(8);
      stop_and_drain();

      // Overrun with a stalled reader and four-word frames
      set_mode(1'b0, 1'b0, 1'b1);
      set_rate(0, 2);
      start_rx(1'b0);
      k = 0;
      @(posedge clk64);
      while (!o_rx_overrun)
      begin
         if (k == WAIT_LIMIT)
            abort_run("timeout waiting for the overrun flag");
         k++;
         @(posedge clk64);
      end
      run_frames(3);
      check_flag("o_rx_overrun", o_rx_overrun, 1'b1);
      popped_before = words_popped;
      stop_and_drain();
      @(posedge clk64);
      check_count("words kept through overrun", words_popped - popped_before, DEPTH);

      // Strobe spacing, short rates first
      set_mode(1'b0, 1'b0, 1'b0);
      for (k = 0; k < 6; k++)
      begin
         if (k < 3)
         begin
            v = 32'(k);
         end
         else
         begin
            draw_bits(8, v);
         end
         write_setting(`RX_ADDR_DECIM, v);
         start_rx(1'b1);
         measure_gaps(int'(v));
         stop_and_drain();
      end

      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== usrp_rx_config.svh ====
/*
 * Receive-side build constants
 *   - settings-bus addresses of the mode and decimation registers
 *   - sample FIFO depth in 16-bit words
 *   - shortest allowed sample strobe period
 */

`ifndef USRP_RX_CONFIG_SVH
`define USRP_RX_CONFIG_SVH

// Settings-bus addresses, 7 bits wide
`define RX_ADDR_MODE  7'd10
`define RX_ADDR_DECIM 7'd11

// FIFO depth in words, must be a power of two
`define RX_FIFO_DEPTH 16

// Four-word frame must finish before the next strobe
`define RX_MIN_PERIOD 4

`endif

// ==== usrp_rx_pkg.sv ====
/*
 * Receive-side shared types
 *   - sample_t      one signed FIFO word
 *   - rate_t        decimation rate setting
 *   - rx_mode_t     mode setting fields
 *   - chan_frame_t  four channels of one sample strobe
 *   - chan_count_t  words per frame
 */

`default_nettype none

package usrp_rx_pkg;

   typedef logic signed [15:0] sample_t;

   typedef logic [7:0] rate_t;

   // Bit 0 is counter, bit 1 loopback, bit 2 four_chan
   typedef struct packed {
      logic four_chan;
      logic loopback;
      logic counter;
   } rx_mode_t;

   // Index 0 is channel 0, in the low bits
   typedef sample_t [3:0] chan_frame_t;

   // Two or four words per frame
   typedef logic [2:0] chan_count_t;

endpackage

`default_nettype wire

// ==== usrp_rx_top.sv ====
/*
 * Receive half of the radio top level
 *   - mode and decimation setting registers
 *   - sample strobe generator
 *   - source selector and sample FIFO joined by the channel link
 */

`default_nettype none

`include "usrp_rx_config.svh"

module usrp_rx_top
(
   input  wire logic                  clk64,
   input  wire logic                  i_rx_dsp_reset,
   input  wire logic                  i_enable_rx,
   input  wire logic                  i_serial_strobe,
   input  wire logic [6:0]            i_serial_addr,
   input  wire logic [31:0]           i_serial_data,
   input  wire usrp_rx_pkg::sample_t  i_adc_i0,
   input  wire usrp_rx_pkg::sample_t  i_adc_q0,
   input  wire usrp_rx_pkg::sample_t  i_adc_i1,
   input  wire usrp_rx_pkg::sample_t  i_adc_q1,
   input  wire usrp_rx_pkg::sample_t  i_tx_i0,
   input  wire usrp_rx_pkg::sample_t  i_tx_q0,
   input  wire logic                  i_tx_strobe,
   input  wire logic                  i_rd,
   input  wire logic                  i_clear_status,
   output logic                       o_sample_strobe,
   output usrp_rx_pkg::sample_t       o_rd_data,
   output logic                       o_empty,
   output logic                       o_rx_overrun
);

   usrp_rx_pkg::rx_mode_t  rx_mode;
   usrp_rx_pkg::rate_t     decim_rate;

   rx_chan_if chan_if ();

   setting_reg #(.ADDR(`RX_ADDR_MODE), .payload_t(usrp_rx_pkg::rx_mode_t)) sr_mode
   (
      .clk64           (clk64),
      .i_rx_dsp_reset  (i_rx_dsp_reset),
      .i_serial_strobe (i_serial_strobe),
      .i_serial_addr   (i_serial_addr),
      .i_serial_data   (i_serial_data),
      .o_value         (rx_mode)
   );

   setting_reg #(.ADDR(`RX_ADDR_DECIM), .payload_t(usrp_rx_pkg::rate_t)) sr_decim
   (
      .clk64           (clk64),
      .i_rx_dsp_reset  (i_rx_dsp_reset),
      .i_serial_strobe (i_serial_strobe),
      .i_serial_addr   (i_serial_addr),
      .i_serial_data   (i_serial_data),
      .o_value         (decim_rate)
   );

   rx_strobe_gen rx_strobe_gen_inst
   (
      .clk64           (clk64),
      .i_rx_dsp_reset  (i_rx_dsp_reset),
      .i_enable_rx     (i_enable_rx),
      .i_decim_rate    (decim_rate),
      .o_sample_strobe (o_sample_strobe)
   );

   rx_source_select rx_source_select_inst
   (
      .clk64           (clk64),
      .i_rx_dsp_reset  (i_rx_dsp_reset),
      .i_enable_rx     (i_enable_rx),
      .i_sample_strobe (o_sample_strobe),
      .i_mode          (rx_mode),
      .i_adc_i0        (i_adc_i0),
      .i_adc_q0        (i_adc_q0),
      .i_adc_i1        (i_adc_i1),
      .i_adc_q1        (i_adc_q1),
      .i_tx_i0         (i_tx_i0),
      .i_tx_q0         (i_tx_q0),
      .i_tx_strobe     (i_tx_strobe),
      .chan            (chan_if.source)
   );

   rx_sample_fifo rx_sample_fifo_inst
   (
      .clk64           (clk64),
      .i_rx_dsp_reset  (i_rx_dsp_reset),
      .chan            (chan_if.sink),
      .i_rd            (i_rd),
      .i_clear_status  (i_clear_status),
      .o_rd_data       (o_rd_data),
      .o_empty         (o_empty),
      .o_rx_overrun    (o_rx_overrun)
   );

endmodule

`default_nettype wire
